// ==== dac_if.sv ====
`timescale 1ns/100ps
`default_nettype none

// commands and update handshake shared by the channels, the sequencer and the dac writer
interface dac_if
    import qla_pkg::*;
#(
    parameter int num_chan = 4
);
    // one commanded current per channel, each driven by its own channel
    cmd_t cmd [num_chan];

    // one-cycle update strobe, only ever raised while busy is low
    logic data_ready;

    // high for the whole serial update
    logic busy;

    modport chan_src (output cmd);
    modport seq (output data_ready, input busy);
    modport writer (input cmd, input data_ready, output busy);

endinterface

`default_nettype wire

// ==== dac_serial_writer.sv ====
`timescale 1ns/100ps
`default_nettype none

module dac_serial_writer
    import qla_pkg::*;
#(
    parameter int num_chan         = 4,
    parameter int sclk_half_period = 1
) (
    input  logic  sysclk,
    input  logic  arst_n,
    dac_if.writer dac,
    output logic  sclk,
    output logic  mosi,
    output logic  csel
);

    // csel stays high this many cycles between frames
    localparam int gap_cycles = 2;
    localparam int fcnt_w     = $clog2(num_chan);
    localparam int bcnt_w     = $clog2(dac_frame_bits);
    localparam int tick_w     = $clog2(sclk_half_period + gap_cycles);

    dac_state_t                state;
    logic [dac_frame_bits-1:0] shreg;
    logic [bcnt_w-1:0]         bit_cnt;
    logic [fcnt_w-1:0]         frame_cnt;
    logic [fcnt_w-1:0]         next_frame;
    logic [tick_w-1:0]         tick_cnt;
    cmd_t                      cmd_lat [num_chan];

    // command nibble, channel address, then the current
    function automatic logic [dac_frame_bits-1:0] make_frame(
        input logic [fcnt_w-1:0] idx,
        input cmd_t              value
    );
        make_frame = {dac_cmd_write_update, 4'(idx), value};
    endfunction

    assign next_frame = frame_cnt + 1'b1;

    // msb goes out first
    assign mosi = shreg[dac_frame_bits-1];

    // snapshot of all commands, taken on the update strobe
    always_ff @(posedge sysclk) begin
        if (state == dac_idle && dac.data_ready) begin
            cmd_lat <= dac.cmd;
        end
    end

    // ------------------------------------------------------------------------
    // frame FSM
    // ------------------------------------------------------------------------

    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= dac_idle;
            dac.busy  <= 1'b0;
            sclk      <= 1'b0;
            csel      <= 1'b1;
            shreg     <= '0;
            bit_cnt   <= '0;
            frame_cnt <= '0;
            tick_cnt  <= '0;
        end else begin
            case (state)
                dac_idle: begin
                    // first frame comes straight from the bus, later ones from the latch
                    if (dac.data_ready) begin
                        shreg     <= make_frame('0, dac.cmd[0]);
                        bit_cnt   <= '0;
                        frame_cnt <= '0;
                        tick_cnt  <= '0;
                        csel      <= 1'b0;
                        dac.busy  <= 1'b1;
                        state     <= dac_shift;
                    end
                end

                dac_shift: begin
                    if (tick_cnt == tick_w'(sclk_half_period - 1)) begin
                        tick_cnt <= '0;
                        sclk     <= ~sclk;
                        // falling sclk edge moves mosi to the next bit
                        if (sclk) begin
                            if (bit_cnt == bcnt_w'(dac_frame_bits - 1)) begin
                                csel  <= 1'b1;
                                state <= dac_gap;
                            end else begin
                                bit_cnt <= bit_cnt + 1'b1;
                                shreg   <= {shreg[dac_frame_bits-2:0], 1'b0};
                            end
                        end
                    end else begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end

                dac_gap: begin
                    if (tick_cnt == tick_w'(gap_cycles - 1)) begin
                        tick_cnt <= '0;
                        if (frame_cnt == fcnt_w'(num_chan - 1)) begin
                            dac.busy <= 1'b0;
                            state    <= dac_idle;
                        end else begin
                            frame_cnt <= next_frame;
                            shreg     <= make_frame(next_frame, cmd_lat[next_frame]);
                            bit_cnt   <= '0;
                            csel      <= 1'b0;
                            state     <= dac_shift;
                        end
                    end else begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end

                default: begin
                    state <= dac_idle;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== dac_update_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

module dac_update_ctrl #(
    parameter int num_chan = 4
) (
    input  logic                sysclk,
    input  logic                arst_n,
    input  logic [num_chan-1:0] cmd_valid_wr,
    input  logic                status_wr,
    input  logic                blk_wen,
    dac_if.seq                  dac
);

    logic dac_wr;
    logic blk_end;
    logic req_in;
    logic pending;
    logic req;

    // any channel took a command with its valid bit set
    assign dac_wr = |cmd_valid_wr;

    // block writes end on the global status register, treat it like blk_wen
    assign blk_end = blk_wen || status_wr;

    // a quadlet write has blk_wen with the dac write, so count this cycle too
    assign req_in = blk_end && (pending || dac_wr);

    // ------------------------------------------------------------------------
    // pending update within a block
    // ------------------------------------------------------------------------

    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            pending <= 1'b0;
        end else if (blk_end) begin
            pending <= 1'b0;
        end else if (dac_wr) begin
            pending <= 1'b1;
        end
    end

    // ------------------------------------------------------------------------
    // request and update strobe
    // ------------------------------------------------------------------------

    // the strobe cycle itself counts as busy, the writer raises busy a cycle later
    // new requests while one waits simply merge into it
    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            req            <= 1'b0;
            dac.data_ready <= 1'b0;
        end else if ((req || req_in) && !dac.busy && !dac.data_ready) begin
            req            <= 1'b0;
            dac.data_ready <= 1'b1;
        end else begin
            dac.data_ready <= 1'b0;
            if (req_in) begin
                req <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== motor_channel.sv ====
`timescale 1ns/100ps
`default_nettype none

module motor_channel
    import qla_pkg::*;
#(
    parameter int chan_idx = 0
) (
    input  logic    sysclk,
    input  logic    arst_n,
    input  logic    wsel,
    input  off_t    waddr_off,
    input  quad_t   wdata,
    input  logic    wdog_timeout,
    input  logic    amp_fault,
    dac_if.chan_src dac,
    output quad_t   status,
    output quad_t   cfg,
    output logic    amp_en_cmd,
    output logic    amp_disable,
    output logic    cmd_valid_wr
);

    logic dac_wsel;
    logic stat_wsel;
    logic cfg_wsel;
    cmd_t cur_cmd;
    logic amp_en;
    logic amp_en_d;
    logic safety;
    logic safety_d;
    logic safety_cause;

    // ------------------------------------------------------------------------
    // register write decode
    // ------------------------------------------------------------------------

    assign dac_wsel  = wsel && (waddr_off == off_dac_ctrl);
    assign stat_wsel = wsel && (waddr_off == off_motor_status);
    assign cfg_wsel  = wsel && (waddr_off == off_motor_config);

    // sequencer only sees writes that carry the valid bit
    assign cmd_valid_wr = dac_wsel && wdata[dac_valid_bit];

    // host asks for this amplifier on, also clears the watchdog upstream
    assign amp_en_cmd = stat_wsel && wdata[amp_en_mask_bit] && wdata[amp_en_value_bit];

    // commanded current, low half of the dac word
    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            cur_cmd <= '0;
        end else if (cmd_valid_wr) begin
            cur_cmd <= cmd_t'(wdata);
        end
    end

    assign dac.cmd[chan_idx] = cur_cmd;

    // configuration word is plain storage
    always_ff @(posedge sysclk) begin
        if (cfg_wsel) begin
            cfg <= wdata;
        end
    end

    // ------------------------------------------------------------------------
    // amplifier enable and safety disable
    // ------------------------------------------------------------------------

    always_comb begin
        amp_en_d = amp_en;
        if (stat_wsel && wdata[amp_en_mask_bit]) begin
            amp_en_d = wdata[amp_en_value_bit];
        end
    end

    // amp_fault is low on a fault, only meaningful with the amplifier on
    assign safety_cause = wdog_timeout || (amp_en && !amp_fault);

    // an enable command only clears the latch once the cause is gone
    always_comb begin
        safety_d = safety;
        if (safety_cause) begin
            safety_d = 1'b1;
        end else if (amp_en_cmd) begin
            safety_d = 1'b0;
        end
    end

    // disable pin follows the next state so it moves on the same edge
    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            amp_en      <= 1'b0;
            safety      <= 1'b0;
            amp_disable <= 1'b1;
        end else begin
            amp_en      <= amp_en_d;
            safety      <= safety_d;
            amp_disable <= !amp_en_d || safety_d;
        end
    end

    // status word, fault bit is the raw feedback (1 means amplifier on)
    always_comb begin
        status                  = '0;
        status[stat_amp_en_bit] = amp_en;
        status[stat_safety_bit] = safety;
        status[stat_fault_bit]  = amp_fault;
    end

endmodule

`default_nettype wire

// ==== project.f ====
qla_pkg.sv
dac_if.sv
motor_channel.sv
dac_update_ctrl.sv
dac_serial_writer.sv
qla_core.sv
qla_checker.sv
qla_tb.sv

// ==== qla_checker.sv ====
`timescale 1ns/100ps
`default_nettype none

// protocol checks on the dac writer and on each motor channel
// inputs that a target does not have are tied to a harmless level at the bind
module qla_checker (
    input logic sysclk,
    input logic arst_n,
    input logic busy,
    input logic data_ready,
    input logic csel,
    input logic wdog_timeout,
    input logic amp_disable
);

    // chip select only drops during an update
    csel_idle_high: assert property (@(posedge sysclk) disable iff (!arst_n) !busy |-> csel)
        else $error("dac chip select low while the writer is idle");

    // sequencer must hold its strobe until the writer is free
    no_strobe_busy: assert property (@(posedge sysclk) disable iff (!arst_n) !(data_ready && busy))
        else $error("dac update strobe raised while the writer is busy");

    // watchdog shuts the amplifier off on the next edge
    wdog_disables: assert property (@(posedge sysclk) disable iff (!arst_n)
        wdog_timeout |=> amp_disable)
        else $error("amplifier still enabled after a watchdog timeout");

endmodule

bind dac_serial_writer qla_checker i_writer_chk (
    .sysclk      (sysclk),
    .arst_n      (arst_n),
    .busy        (dac.busy),
    .data_ready  (dac.data_ready),
    .csel        (csel),
    .wdog_timeout(1'b0),
    .amp_disable (1'b1)
);

bind motor_channel qla_checker i_chan_chk (
    .sysclk      (sysclk),
    .arst_n      (arst_n),
    .busy        (1'b1),
    .data_ready  (1'b0),
    .csel        (1'b1),
    .wdog_timeout(wdog_timeout),
    .amp_disable (amp_disable)
);

`default_nettype wire

// ==== qla_core.sv ====
`timescale 1ns/100ps
`default_nettype none

module qla_core
    import qla_pkg::*;
#(
    parameter int num_chan         = qla_pkg::num_chan,
    parameter int sclk_half_period = 1
) (
    input  logic                sysclk,
    input  logic                arst_n,
    input  addr_t               reg_raddr,
    input  addr_t               reg_waddr,
    input  quad_t               reg_wdata,
    output quad_t               reg_rdata,
    input  logic                reg_wen,
    input  logic                blk_wen,
    input  logic [3:0]          board_id,
    input  logic                wdog_timeout,
    input  logic [num_chan-1:0] amp_fault,
    output logic                wdog_clear,
    output logic [num_chan-1:0] amp_disable,
    output logic                dac_sclk,
    output logic                dac_mosi,
    output logic                dac_csel
);

    region_t             w_region;
    chan_t               w_chan;
    off_t                w_off;
    region_t             r_region;
    chan_t               r_chan;
    off_t                r_off;
    logic                main_wen;
    logic                status_wr;
    logic                pwr_en_cmd;
    logic                pwr_en;
    logic [31:0]         timestamp;
    logic [num_chan-1:0] wsel;
    logic [num_chan-1:0] amp_en_cmd;
    logic [num_chan-1:0] cmd_valid_wr;
    logic [num_chan-1:0] safety;
    quad_t               status [num_chan];
    quad_t               cfg [num_chan];
    quad_t               glob_status;
    quad_t               chan_rdata;

    dac_if #(.num_chan(num_chan)) dac_bus ();

    // ------------------------------------------------------------------------
    // write decode
    // ------------------------------------------------------------------------

    assign w_region = reg_waddr[15:12];
    assign w_chan   = reg_waddr[7:4];
    assign w_off    = reg_waddr[3:0];

    assign main_wen  = reg_wen && (w_region == addr_main);
    assign status_wr = main_wen && (w_chan == '0) && (w_off == off_status);

    assign pwr_en_cmd = status_wr && reg_wdata[pwr_en_mask_bit] && reg_wdata[pwr_en_value_bit];

    // host is trying to power the board or any amplifier
    assign wdog_clear = pwr_en_cmd || (|amp_en_cmd);

    // board power enable, mask bit gates the write
    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            pwr_en <= 1'b0;
        end else if (status_wr && reg_wdata[pwr_en_mask_bit]) begin
            pwr_en <= reg_wdata[pwr_en_value_bit];
        end
    end

    // free-running timestamp
    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            timestamp <= '0;
        end else begin
            timestamp <= timestamp + 32'd1;
        end
    end

    // ------------------------------------------------------------------------
    // motor channels, bus channel i+1 maps to instance i
    // ------------------------------------------------------------------------

    for (genvar i = 0; i < num_chan; i++) begin : g_chan
        assign wsel[i]   = main_wen && (w_chan == chan_t'(i + 1));
        assign safety[i] = status[i][stat_safety_bit];

        motor_channel #(
            .chan_idx(i)
        ) i_chan (
            .sysclk      (sysclk),
            .arst_n      (arst_n),
            .wsel        (wsel[i]),
            .waddr_off   (w_off),
            .wdata       (reg_wdata),
            .wdog_timeout(wdog_timeout),
            .amp_fault   (amp_fault[i]),
            .dac         (dac_bus),
            .status      (status[i]),
            .cfg         (cfg[i]),
            .amp_en_cmd  (amp_en_cmd[i]),
            .amp_disable (amp_disable[i]),
            .cmd_valid_wr(cmd_valid_wr[i])
        );
    end

    // ------------------------------------------------------------------------
    // dac update path
    // ------------------------------------------------------------------------

    dac_update_ctrl #(
        .num_chan(num_chan)
    ) i_dac_update (
        .sysclk      (sysclk),
        .arst_n      (arst_n),
        .cmd_valid_wr(cmd_valid_wr),
        .status_wr   (status_wr),
        .blk_wen     (blk_wen),
        .dac         (dac_bus)
    );

    dac_serial_writer #(
        .num_chan        (num_chan),
        .sclk_half_period(sclk_half_period)
    ) i_dac_writer (
        .sysclk(sysclk),
        .arst_n(arst_n),
        .dac   (dac_bus),
        .sclk  (dac_sclk),
        .mosi  (dac_mosi),
        .csel  (dac_csel)
    );

    // ------------------------------------------------------------------------
    // read mux, answers in the same cycle
    // ------------------------------------------------------------------------

    assign r_region = reg_raddr[15:12];
    assign r_chan   = reg_raddr[7:4];
    assign r_off    = reg_raddr[3:0];

    always_comb begin
        glob_status = '0;
        glob_status[gstat_board_id_lsb +: 4]      = board_id;
        glob_status[gstat_pwr_bit]                = pwr_en;
        glob_status[gstat_safety_lsb +: num_chan] = safety;
        glob_status[gstat_fault_lsb +: num_chan]  = amp_fault;
    end

    // channels outside 1..num_chan fall through as zero
    always_comb begin
        chan_rdata = '0;
        for (int i = 0; i < num_chan; i++) begin
            if (r_chan == chan_t'(i + 1)) begin
                case (r_off)
                    off_dac_ctrl:     chan_rdata = quad_t'(dac_bus.cmd[i]);
                    off_motor_status: chan_rdata = status[i];
                    off_motor_config: chan_rdata = cfg[i];
                    default:          chan_rdata = '0;
                endcase
            end
        end
    end

    always_comb begin
        reg_rdata = '0;
        if (r_region == addr_main) begin
            if (r_chan == '0) begin
                case (r_off)
                    off_status:    reg_rdata = glob_status;
                    off_timestamp: reg_rdata = timestamp;
                    default:       reg_rdata = '0;
                endcase
            end else begin
                reg_rdata = chan_rdata;
            end
        end
    end

endmodule

`default_nettype wire

// ==== qla_pkg.sv ====
`default_nettype none

// shared register map, widths and dac frame format for the motor board
package qla_pkg;

    // ------------------------------------------------------------------------
    // widths
    // ------------------------------------------------------------------------

    // number of motor channels on the board
    localparam int num_chan = 4;

    // bus data word and bus address
    typedef logic [31:0] quad_t;
    typedef logic [15:0] addr_t;

    // commanded current, as sent to the dac
    typedef logic [15:0] cmd_t;

    // region sits in address bits 15:12
    typedef logic [3:0] region_t;
    // channel sits in address bits 7:4, channel 0 is the board itself
    typedef logic [3:0] chan_t;
    // register offset sits in address bits 3:0
    typedef logic [3:0] off_t;

    // ------------------------------------------------------------------------
    // register map
    // ------------------------------------------------------------------------

    localparam region_t addr_main = 4'h0;

    // global registers, channel 0
    localparam off_t off_status    = 4'd0;
    localparam off_t off_timestamp = 4'd10;

    // per channel registers, channels 1 to num_chan
    localparam off_t off_dac_ctrl     = 4'd0;
    localparam off_t off_motor_status = 4'd12;
    localparam off_t off_motor_config = 4'd13;

    // dac write only counts when this bit is set
    localparam int dac_valid_bit = 31;

    // motor status write, mask bit enables the value bit
    localparam int amp_en_mask_bit  = 9;
    localparam int amp_en_value_bit = 8;

    // global status write, same mask/value scheme for board power
    localparam int pwr_en_mask_bit  = 19;
    localparam int pwr_en_value_bit = 18;

    // motor status read bits
    localparam int stat_amp_en_bit = 29;
    localparam int stat_safety_bit = 17;
    localparam int stat_fault_bit  = 16;

    // global status read layout, lsb of each field
    localparam int gstat_board_id_lsb = 24;
    localparam int gstat_pwr_bit      = 18;
    localparam int gstat_safety_lsb   = 8;
    localparam int gstat_fault_lsb    = 0;

    // ------------------------------------------------------------------------
    // dac serial frame
    // ------------------------------------------------------------------------

    // command nibble, channel nibble, then 16 data bits, msb first
    localparam int dac_frame_bits = 24;
    // write input register and update output
    localparam logic [3:0] dac_cmd_write_update = 4'h3;

    // dac writer states
    typedef enum logic [1:0] {
        dac_idle,
        dac_shift,
        dac_gap
    } dac_state_t;

endpackage

`default_nettype wire

// ==== qla_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module qla_tb
    import qla_pkg::*;
();

    localparam int max_rows = 16;

    logic       sysclk;
    logic       arst_n;
    addr_t      reg_raddr;
    addr_t      reg_waddr;
    quad_t      reg_wdata;
    quad_t      reg_rdata;
    logic       reg_wen;
    logic       blk_wen;
    logic [3:0] board_id;
    logic       wdog_timeout;
    logic [3:0] amp_fault;
    logic       wdog_clear;
    logic [3:0] amp_disable;
    logic       dac_sclk;
    logic       dac_mosi;
    logic       dac_csel;

    int quad_errs;
    int cmd_errs;
    int bit_errs;
    int other_errs;
    integer seed;
    logic wclr_seen;

    // rebuilt dac frames in arrival order
    logic [23:0] frame_sr;
    int          bit_num;
    logic [23:0] frames [$];

    // register table with an optional write and a read against its expected value
    logic  row_wen [max_rows];
    addr_t row_waddr [max_rows];
    quad_t row_wdata [max_rows];
    logic  row_blk [max_rows];
    addr_t row_raddr [max_rows];
    quad_t row_exp [max_rows];
    int    num_rows;

    qla_core #(
        .num_chan        (num_chan),
        .sclk_half_period(1)
    ) i_dut (
        .sysclk      (sysclk),
        .arst_n      (arst_n),
        .reg_raddr   (reg_raddr),
        .reg_waddr   (reg_waddr),
        .reg_wdata   (reg_wdata),
        .reg_rdata   (reg_rdata),
        .reg_wen     (reg_wen),
        .blk_wen     (blk_wen),
        .board_id    (board_id),
        .wdog_timeout(wdog_timeout),
        .amp_fault   (amp_fault),
        .wdog_clear  (wdog_clear),
        .amp_disable (amp_disable),
        .dac_sclk    (dac_sclk),
        .dac_mosi    (dac_mosi),
        .dac_csel    (dac_csel)
    );

    always #5 sysclk = ~sysclk;

    // ------------------------------------------------------------------------
    // dac frame decoder
    // ------------------------------------------------------------------------

    // mosi is sampled on the rising sclk edge where it is stable
    always @(posedge dac_sclk or negedge arst_n) begin
        if (!arst_n) begin
            bit_num = 0;
        end else if (!dac_csel) begin
            frame_sr = {frame_sr[22:0], dac_mosi};
            bit_num  = bit_num + 1;
            if (bit_num == dac_frame_bits) begin
                frames.push_back(frame_sr);
                bit_num = 0;
            end
        end
    end

    // ------------------------------------------------------------------------
    // compare tasks
    // ------------------------------------------------------------------------

    task automatic check_quad(input string name, input quad_t got, input quad_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
            quad_errs++;
        end
    endtask

    task automatic check_cmd(input string name, input cmd_t got, input cmd_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
            cmd_errs++;
        end
    endtask

    task automatic check_bits(input string name, input logic [3:0] got, input logic [3:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
            bit_errs++;
        end
    endtask

    // ------------------------------------------------------------------------
    // bus access
    // ------------------------------------------------------------------------

    // write lands on the second edge and wdog_clear is sampled in between
    task automatic bus_write(input addr_t addr, input quad_t data, input logic blk);
        @(posedge sysclk);
        reg_waddr <= addr;
        reg_wdata <= data;
        reg_wen   <= 1'b1;
        blk_wen   <= blk;
        @(negedge sysclk);
        wclr_seen = wdog_clear;
        @(posedge sysclk);
        reg_wen <= 1'b0;
        blk_wen <= 1'b0;
    endtask

    task automatic bus_read(input addr_t addr, output quad_t data);
        @(posedge sysclk);
        reg_raddr <= addr;
        @(negedge sysclk);
        data = reg_rdata;
    endtask

    // dac commands of all channels with blk_wen on the last quadlet only
    task automatic write_block(input cmd_t vals [num_chan]);
        for (int i = 0; i < num_chan; i++) begin
            bus_write(addr_t'((i + 1) * 16), {1'b1, 15'h0, vals[i]}, i == num_chan - 1);
        end
    endtask

    task automatic add_row(input logic wen, input addr_t waddr, input quad_t wdata,
                           input logic blk, input addr_t raddr, input quad_t exp);
        row_wen[num_rows]   = wen;
        row_waddr[num_rows] = waddr;
        row_wdata[num_rows] = wdata;
        row_blk[num_rows]   = blk;
        row_raddr[num_rows] = raddr;
        row_exp[num_rows]   = exp;
        num_rows++;
    endtask

    task automatic wait_frames(input int count, input int max_cycles);
        int n;
        n = 0;
        while (frames.size() < count && n < max_cycles) begin
            @(negedge sysclk);
            n++;
        end
        if (frames.size() < count) begin
            $display("timed out waiting for %0d dac frames, only %0d seen", count, frames.size());
            other_errs++;
        end
    endtask

    task automatic wait_csel_low(input int max_cycles);
        int n;
        n = 0;
        while (dac_csel && n < max_cycles) begin
            @(negedge sysclk);
            n++;
        end
        if (dac_csel) begin
            $display("timed out waiting for the dac update to start");
            other_errs++;
        end
    endtask

    // four frames of write-update command 0x3, channel address and current
    task automatic check_update(input int first, input cmd_t vals [num_chan]);
        for (int j = 0; j < num_chan; j++) begin
            check_quad("dac frame header", quad_t'(frames[first + j][23:16]),
                       quad_t'({4'h3, 4'(j)}));
            check_cmd("dac frame data", frames[first + j][15:0], vals[j]);
        end
    endtask

    // ------------------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------------------

    initial begin
        cmd_t  cmd_a [num_chan];
        cmd_t  cmd_b [num_chan];
        cmd_t  cmd_c [num_chan];
        quad_t rd;
        quad_t t0;
        quad_t t1;
        sysclk       = 1'b0;
        arst_n       = 1'b0;
        reg_raddr    = '0;
        reg_waddr    = '0;
        reg_wdata    = '0;
        reg_wen      = 1'b0;
        blk_wen      = 1'b0;
        board_id     = 4'hA;
        wdog_timeout = 1'b0;
        amp_fault    = 4'hF;
        quad_errs    = 0;
        cmd_errs     = 0;
        bit_errs     = 0;
        other_errs   = 0;
        num_rows     = 0;
        seed         = 55167;
        for (int i = 0; i < num_chan; i++) begin
            cmd_a[i] = cmd_t'($random(seed));
            cmd_b[i] = cmd_t'($random(seed));
            cmd_c[i] = cmd_t'($random(seed));
        end
        repeat (16) @(posedge sysclk);
        arst_n <= 1'b1;

        // reset state
        @(negedge sysclk);
        check_bits("amp_disable", amp_disable, 4'hF);
        check_bits("dac_csel", {3'b000, dac_csel}, 4'b0001);
        check_bits("wdog_clear", {3'b000, wdog_clear}, 4'b0000);

        // status reads, dac block, invalid dac writes, config words
        for (int i = 0; i < num_chan; i++) begin
            add_row(1'b0, '0, '0, 1'b0, addr_t'((i + 1) * 16 + 12), 32'h0001_0000);
        end
        add_row(1'b0, '0, '0, 1'b0, 16'h0000, 32'h0A00_000F);
        for (int i = 0; i < num_chan; i++) begin
            add_row(1'b1, addr_t'((i + 1) * 16), {1'b1, 15'h0, cmd_a[i]}, i == num_chan - 1,
                    addr_t'((i + 1) * 16), quad_t'(cmd_a[i]));
        end
        add_row(1'b1, 16'h0010, 32'h0000_1234, 1'b0, 16'h0010, quad_t'(cmd_a[0]));
        add_row(1'b1, 16'h0030, 32'h0000_ABCD, 1'b0, 16'h0030, quad_t'(cmd_a[2]));
        add_row(1'b1, 16'h002D, 32'h5A5A_1234, 1'b0, 16'h002D, 32'h5A5A_1234);
        add_row(1'b1, 16'h004D, 32'h0F0F_8001, 1'b0, 16'h004D, 32'h0F0F_8001);
        for (int r = 0; r < num_rows; r++) begin
            if (row_wen[r]) begin
                bus_write(row_waddr[r], row_wdata[r], row_blk[r]);
            end
            bus_read(row_raddr[r], rd);
            check_quad($sformatf("reg_rdata[%h]", row_raddr[r]), rd, row_exp[r]);
        end

        // timestamp advances by one per cycle
        bus_read(16'h000A, t0);
        repeat (37) @(negedge sysclk);
        t1 = reg_rdata;
        check_quad("timestamp delta", t1 - t0, 32'd37);

        // single update from the table block
        wait_frames(4, 2000);
        check_update(0, cmd_a);

        // second block during busy is held back until the first update ends
        write_block(cmd_b);
        wait_csel_low(20);
        write_block(cmd_c);
        wait_frames(12, 3000);
        check_update(4, cmd_b);
        check_update(8, cmd_c);
        repeat (300) @(negedge sysclk);
        if (frames.size() != 12) begin
            $display("expected exactly two dac updates, saw %0d frames", frames.size() - 4);
            other_errs++;
        end

        // amplifier enable on channel 2 and board power
        bus_write(16'h002C, 32'h0000_0300, 1'b0);
        check_bits("wdog_clear", {3'b000, wclr_seen}, 4'b0001);
        @(negedge sysclk);
        check_bits("amp_disable", amp_disable, 4'b1101);
        bus_read(16'h002C, rd);
        check_quad("motor status 2", rd, 32'h2001_0000);
        bus_write(16'h0000, 32'h000C_0000, 1'b0);
        check_bits("wdog_clear", {3'b000, wclr_seen}, 4'b0001);
        bus_read(16'h0000, rd);
        check_quad("global status", rd, 32'h0A04_000F);

        // watchdog timeout trips every channel
        @(posedge sysclk);
        wdog_timeout <= 1'b1;
        @(posedge sysclk);
        wdog_timeout <= 1'b0;
        @(negedge sysclk);
        check_bits("amp_disable", amp_disable, 4'hF);
        bus_read(16'h002C, rd);
        check_quad("motor status 2", rd, 32'h2003_0000);
        bus_read(16'h0000, rd);
        check_quad("global status", rd, 32'h0A04_0F0F);
        bus_write(16'h002C, 32'h0000_0300, 1'b0);
        @(negedge sysclk);
        check_bits("amp_disable", amp_disable, 4'b1101);

        // amplifier fault on the enabled channel
        @(posedge sysclk);
        amp_fault <= 4'b1101;
        @(posedge sysclk);
        @(negedge sysclk);
        check_bits("amp_disable", amp_disable, 4'hF);
        bus_read(16'h002C, rd);
        check_quad("motor status 2", rd, 32'h2002_0000);
        @(posedge sysclk);
        amp_fault <= 4'hF;
        bus_write(16'h002C, 32'h0000_0300, 1'b0);
        @(negedge sysclk);
        check_bits("amp_disable", amp_disable, 4'b1101);
        bus_read(16'h002C, rd);
        check_quad("motor status 2", rd, 32'h2001_0000);

        $display("errors: quad %0d, cmd %0d, bits %0d, other %0d",
                 quad_errs, cmd_errs, bit_errs, other_errs);
        if (quad_errs + cmd_errs + bit_errs + other_errs == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with verilator, run it and look for the pass line in the log
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module qla_tb \
    -f project.f -o qla_sim \
    && ./obj_dir/qla_sim > sim.log 2>&1 \
    || echo "build or simulation did not complete"
grep -q "Everything OK" sim.log && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }
